//--- accel_cfg_pkg.sv
package accel_cfg_pkg;

    // source buffer size and addressing
    localparam int SRC_DEPTH = 64;
    localparam int IDX_W     = 6;
    // sequence and gram lengths go up to SRC_DEPTH, so one extra bit
    localparam int LEN_W     = IDX_W + 1;

    // polynomial hash
    localparam int HASH_MUL  = 31;
    localparam int HASH_W    = 16;

    // result queue
    localparam int Q_DEPTH   = 4;
    localparam int Q_PTR_W   = $clog2(Q_DEPTH);
    localparam int Q_CNT_W   = $clog2(Q_DEPTH + 1);

endpackage

//--- accel_types_pkg.sv
package accel_types_pkg;

    import accel_cfg_pkg::*;

    // one source byte
    typedef logic [7:0]        byte_t;

    // loop index or buffer address
    typedef logic [IDX_W-1:0]  idx_t;

    // job lengths, 1..SRC_DEPTH
    typedef logic [LEN_W-1:0]  len_t;

    // one hash value
    typedef logic [HASH_W-1:0] hash_t;

endpackage

//--- exec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exec_if import accel_types_pkg::*; ();

    // loop state, all driven by the controller
    logic exec;
    logic first_j;
    logic last_j;
    logic k_fin;
    idx_t i;
    idx_t j;

    modport ctrl (output exec, output i, output j,
                  output first_j, output last_j, output k_fin);

    // buffer only needs the address and the read enable
    modport rd   (input exec, input i, input j);

    // hasher needs the gram framing
    modport acc  (input exec, input first_j, input last_j);

endinterface

`default_nettype wire

//--- agu_next.sv
`timescale 1ns/1ps
`default_nettype none

module agu_next import accel_types_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    input  logic en_i,
    input  idx_t ini_i,
    input  idx_t fin_i,
    output idx_t data_o,
    output logic last_o,
    output logic next_o
);

    // last step of this loop level
    assign last_o = en_i & (data_o == fin_i);

    // counter with wrap back to ini
    always_ff @(posedge clk) begin
        if (rst) begin
            data_o <= '0;
            next_o <= 1'b0;
        end else begin
            next_o <= 1'b0;
            if (start_i) begin
                data_o <= ini_i;
            end else if (en_i) begin
                if (data_o == fin_i) begin
                    // wrapped, tell the outer level
                    data_o <= ini_i;
                    next_o <= 1'b1;
                end else begin
                    data_o <= data_o + 1'b1;
                end
            end
        end
    end

    // bounds come from the controller, count must stay inside them
    a_in_range: assert property (@(posedge clk) disable iff (rst)
        en_i |-> data_o <= fin_i);

endmodule

`default_nettype wire

//--- exe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exe_ctrl import accel_types_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic s_init_i,
    input  len_t seq_len_i,
    input  len_t gram_len_i,
    input  logic out_busy_i,
    input  logic out_fin_i,
    exec_if.ctrl ex,
    output logic s_fin_o
);

    idx_t i_fin;
    idx_t j_fin;
    idx_t i;
    idx_t j;
    logic k_init;
    logic k_init_next;
    logic exec;
    logic last_i;
    logic last_j;
    logic next_i;
    logic next_j;
    logic s_fin_period;

    // loop bounds, latched with the start strobe
    always_ff @(posedge clk) begin
        if (s_init_i) begin
            i_fin <= idx_t'(seq_len_i - gram_len_i);
            j_fin <= idx_t'(gram_len_i - 1'b1);
        end
    end

    //////////////////////////////////////////////////
    // gram launch
    //////////////////////////////////////////////////

    // first gram from the job start, later ones from k_init_next
    assign k_init = (s_init_i | k_init_next) & ~out_busy_i;

    // exec: one cycle after k_init, through last_j
    always_ff @(posedge clk) begin
        if (rst) begin
            exec <= 1'b0;
        end else begin
            exec <= k_init | (exec & ~last_j);
        end
    end

    // pending launch, held while the queue drains
    always_ff @(posedge clk) begin
        if (rst) begin
            k_init_next <= 1'b0;
        end else if (s_init_i | k_init) begin
            k_init_next <= 1'b0;
        end else if (last_j & ~last_i) begin
            k_init_next <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // loop counters
    //////////////////////////////////////////////////

    // i loop, one step per gram
    agu_next l_i (
        .clk     (clk),
        .rst     (rst),
        .start_i (s_init_i),
        .en_i    (last_j),
        .ini_i   ('0),
        .fin_i   (i_fin),
        .data_o  (i),
        .last_o  (last_i),
        .next_o  (next_i)
    );

    // j loop, bytes of one gram
    agu_next l_j (
        .clk     (clk),
        .rst     (rst),
        .start_i (k_init),
        .en_i    (exec),
        .ini_i   ('0),
        .fin_i   (j_fin),
        .data_o  (j),
        .last_o  (last_j),
        .next_o  (next_j)
    );

    //////////////////////////////////////////////////
    // job finish
    //////////////////////////////////////////////////

    // opens on the i wrap so the last hash is already on its way to the queue
    always_ff @(posedge clk) begin
        if (rst) begin
            s_fin_period <= 1'b0;
        end else if (next_i) begin
            s_fin_period <= 1'b1;
        end else if (out_fin_i) begin
            s_fin_period <= 1'b0;
        end
    end

    // done pulse, cycle after the queue is empty
    always_ff @(posedge clk) begin
        if (rst) begin
            s_fin_o <= 1'b0;
        end else begin
            s_fin_o <= s_fin_period & out_fin_i;
        end
    end

    // loop state out to buffer and hasher
    assign ex.exec    = exec;
    assign ex.i       = i;
    assign ex.j       = j;
    assign ex.first_j = exec & (j == '0);
    assign ex.last_j  = last_j;
    // j wrap is one cycle after last_j
    assign ex.k_fin   = next_j;

    // no new gram once the job is closing
    a_no_exec_in_fin: assert property (@(posedge clk) disable iff (rst)
        s_fin_period |-> !exec);

endmodule

`default_nettype wire

//--- src_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module src_buffer import accel_cfg_pkg::*, accel_types_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  load_stb_i,
    input  byte_t load_byte_i,
    input  logic  clear_i,
    exec_if.rd    rd,
    output byte_t rd_byte_o
);

    byte_t mem [SRC_DEPTH];
    len_t  wr_ptr;
    idx_t  rd_addr;

    // host write pointer, back to 0 after each job
    always_ff @(posedge clk) begin
        if (rst | clear_i) begin
            wr_ptr <= '0;
        end else if (load_stb_i) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // byte store
    always_ff @(posedge clk) begin
        if (load_stb_i) begin
            mem[wr_ptr[IDX_W-1:0]] <= load_byte_i;
        end
    end

    // gram i, byte j
    assign rd_addr = rd.i + rd.j;

    // registered read, data one cycle after exec
    always_ff @(posedge clk) begin
        if (rd.exec) begin
            rd_byte_o <= mem[rd_addr];
        end
    end

    // host must not load more than the buffer holds
    a_wr_in_range: assert property (@(posedge clk) disable iff (rst)
        load_stb_i |-> wr_ptr < len_t'(SRC_DEPTH));

endmodule

`default_nettype wire

//--- ngram_hasher.sv
`timescale 1ns/1ps
`default_nettype none

module ngram_hasher import accel_cfg_pkg::*, accel_types_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    exec_if.acc   acc,
    input  byte_t rd_byte_i,
    output logic  hash_stb_o,
    output hash_t hash_o
);

    logic  exec_d;
    logic  first_d;
    logic  last_d;
    hash_t h_acc;
    hash_t h_base;
    hash_t h_next;

    // framing delayed to meet the buffer read data
    always_ff @(posedge clk) begin
        if (rst) begin
            exec_d  <= 1'b0;
            first_d <= 1'b0;
            last_d  <= 1'b0;
        end else begin
            exec_d  <= acc.exec;
            first_d <= acc.first_j;
            last_d  <= acc.last_j;
        end
    end

    // h*31 + byte, wraps at 2^16
    assign h_base = first_d ? '0 : h_acc;
    assign h_next = h_base * hash_t'(HASH_MUL) + hash_t'(rd_byte_i);

    // accumulator
    always_ff @(posedge clk) begin
        if (exec_d) begin
            h_acc <= h_next;
        end
    end

    // one result per gram, after its last byte
    always_ff @(posedge clk) begin
        if (rst) begin
            hash_stb_o <= 1'b0;
        end else begin
            hash_stb_o <= exec_d & last_d;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_d & last_d) begin
            hash_o <= h_next;
        end
    end

endmodule

`default_nettype wire

//--- dst_writer.sv
`timescale 1ns/1ps
`default_nettype none

module dst_writer import accel_cfg_pkg::*, accel_types_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  hash_stb_i,
    input  hash_t hash_i,
    output logic  res_stb_o,
    output hash_t res_hash_o,
    output logic  out_busy_o,
    output logic  out_fin_o
);

    hash_t              q_mem [Q_DEPTH];
    logic [Q_PTR_W-1:0] wr_ptr;
    logic [Q_PTR_W-1:0] rd_ptr;
    logic [Q_CNT_W-1:0] count;
    logic               q_empty;
    logic               q_full;
    logic               pop;

    assign q_empty = (count == '0);
    assign q_full  = (count == Q_CNT_W'(Q_DEPTH));
    // drain whenever something is queued
    assign pop     = ~q_empty;

    // circular queue pointers and fill level
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (hash_stb_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + Q_CNT_W'(hash_stb_i) - Q_CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (hash_stb_i) begin
            q_mem[wr_ptr] <= hash_i;
        end
    end

    // result strobe, one entry per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            res_stb_o <= 1'b0;
        end else begin
            res_stb_o <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            res_hash_o <= q_mem[rd_ptr];
        end
    end

    // back-pressure and drain status for the controller
    assign out_busy_o = ~q_empty;
    assign out_fin_o  = q_empty & ~hash_stb_i;

    // controller throttling must keep the queue from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        hash_stb_i |-> !q_full);

endmodule

`default_nettype wire

//--- ngram_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

module ngram_accel_top import accel_types_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  load_stb_i,
    input  byte_t load_byte_i,
    input  logic  start_stb_i,
    input  len_t  seq_len_i,
    input  len_t  gram_len_i,
    output logic  res_stb_o,
    output hash_t res_hash_o,
    output logic  done_o
);

    logic  out_busy;
    logic  out_fin;
    logic  hash_stb;
    hash_t hash;
    byte_t rd_byte;

    // loop state bundle
    exec_if ex_if ();

    // done also rewinds the host write pointer
    exe_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .s_init_i   (start_stb_i),
        .seq_len_i  (seq_len_i),
        .gram_len_i (gram_len_i),
        .out_busy_i (out_busy),
        .out_fin_i  (out_fin),
        .ex         (ex_if.ctrl),
        .s_fin_o    (done_o)
    );

    src_buffer u_src (
        .clk         (clk),
        .rst         (rst),
        .load_stb_i  (load_stb_i),
        .load_byte_i (load_byte_i),
        .clear_i     (done_o),
        .rd          (ex_if.rd),
        .rd_byte_o   (rd_byte)
    );

    ngram_hasher u_hash (
        .clk        (clk),
        .rst        (rst),
        .acc        (ex_if.acc),
        .rd_byte_i  (rd_byte),
        .hash_stb_o (hash_stb),
        .hash_o     (hash)
    );

    dst_writer u_dst (
        .clk        (clk),
        .rst        (rst),
        .hash_stb_i (hash_stb),
        .hash_i     (hash),
        .res_stb_o  (res_stb_o),
        .res_hash_o (res_hash_o),
        .out_busy_o (out_busy),
        .out_fin_o  (out_fin)
    );

endmodule

`default_nettype wire

//--- tb_ngram_accel.sv
`timescale 1ns/1ps

module tb_ngram_accel import accel_types_pkg::*; ();

    localparam int NUM_ROWS  = 9;
    localparam int MODE_RAND = 0;
    localparam int MODE_ZERO = 1;
    localparam int MODE_ASC  = 2;

    // stimulus table: sequence length, gram length, data mode
    int row_seq  [NUM_ROWS] = '{8, 64, 1, 10, 5, 64, 64, 16, 20};
    int row_gram [NUM_ROWS] = '{8, 64, 1, 1, 1, 3, 7, 4, 5};
    int row_mode [NUM_ROWS] = '{MODE_ASC, MODE_RAND, MODE_RAND, MODE_RAND, MODE_ASC,
                                MODE_RAND, MODE_RAND, MODE_ZERO, MODE_ASC};

    logic  clk;
    logic  rst;
    logic  load_stb_i;
    byte_t load_byte_i;
    logic  start_stb_i;
    len_t  seq_len_i;
    len_t  gram_len_i;
    logic  res_stb_o;
    hash_t res_hash_o;
    logic  done_o;

    // current job data and expected hashes
    byte_t       tb_data  [64];
    hash_t       exp_hash [64];
    int          exp_cnt;
    logic [15:0] lfsr_state;

    // monitor state
    int   res_cnt;
    int   jobs_done;
    logic job_active;
    logic seen_start;

    int cycle_cnt;
    int timeout_limit;

    ngram_accel_top uut (
        .clk         (clk),
        .rst         (rst),
        .load_stb_i  (load_stb_i),
        .load_byte_i (load_byte_i),
        .start_stb_i (start_stb_i),
        .seq_len_i   (seq_len_i),
        .gram_len_i  (gram_len_i),
        .res_stb_o   (res_stb_o),
        .res_hash_o  (res_hash_o),
        .done_o      (done_o)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s at %0t ns", reason, $time);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1, one bit per step
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic next_rand_byte(output byte_t b);
        b = '0;
        for (int k = 0; k < 8; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    // reference: h = h*31 + byte, modulo 2^16, fresh per gram
    function automatic hash_t model_hash(input int first, input int len);
        hash_t h;
        h = '0;
        for (int k = 0; k < len; k++) begin
            h = h * 16'd31 + {8'h00, tb_data[first + k]};
        end
        return h;
    endfunction

    function automatic int compute_timeout();
        int total;
        int grams;
        total = 100;
        for (int r = 0; r < NUM_ROWS; r++) begin
            grams = row_seq[r] - row_gram[r] + 1;
            total += row_seq[r] + 3 * grams * (row_gram[r] + 4);
        end
        return total;
    endfunction

    task automatic fill_row_data(input int mode, input int n);
        byte_t b;
        for (int k = 0; k < n; k++) begin
            case (mode)
                MODE_ZERO: b = 8'h00;
                MODE_ASC:  b = byte_t'(k);
                default:   next_rand_byte(b);
            endcase
            tb_data[k] = b;
        end
    endtask

    // one byte per cycle, then the start strobe right behind it
    task automatic load_and_start(input int seq, input int gram);
        for (int k = 0; k < seq; k++) begin
            @(posedge clk);
            #5;
            load_stb_i  = 1'b1;
            load_byte_i = tb_data[k];
        end
        @(posedge clk);
        #5;
        load_stb_i  = 1'b0;
        load_byte_i = '0;
        start_stb_i = 1'b1;
        seq_len_i   = len_t'(seq);
        gram_len_i  = len_t'(gram);
        @(posedge clk);
        #5;
        start_stb_i = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // output monitor, sampled mid-cycle
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst || !seen_start) begin
            // nothing may come out before the first job
            if (res_stb_o) begin
                abort_run("result strobe seen during reset or before the first start");
            end
            if (done_o) begin
                abort_run("done seen during reset or before the first start");
            end
            if (!rst && start_stb_i) begin
                seen_start = 1'b1;
                job_active = 1'b1;
                res_cnt    = 0;
            end
        end else begin
            if (start_stb_i) begin
                job_active = 1'b1;
                res_cnt    = 0;
            end
            if (res_stb_o) begin
                if (!job_active) begin
                    abort_run("result strobe seen after done with no job running");
                end
                if (res_cnt >= exp_cnt) begin
                    check_value("result count", 32'(res_cnt + 1), 32'(exp_cnt));
                end
                check_value($sformatf("hash of gram %0d", res_cnt),
                            32'(res_hash_o), 32'(exp_hash[res_cnt]));
                res_cnt++;
            end
            if (done_o) begin
                if (!job_active) begin
                    abort_run("second done pulse for one job");
                end
                // all hashes must be out before done
                check_value("results before done", 32'(res_cnt), 32'(exp_cnt));
                job_active = 1'b0;
                jobs_done++;
            end
        end
    end

    // hang guard
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            abort_run("run timed out waiting for the DUT");
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        rst           = 1'b1;
        load_stb_i    = 1'b0;
        load_byte_i   = '0;
        start_stb_i   = 1'b0;
        seq_len_i     = '0;
        gram_len_i    = '0;
        lfsr_state    = 16'd27262;
        exp_cnt       = 0;
        res_cnt       = 0;
        jobs_done     = 0;
        job_active    = 1'b0;
        seen_start    = 1'b0;
        cycle_cnt     = 0;
        timeout_limit = compute_timeout();

        // reset for two edges
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;

        // idle time with no start, monitor watches for stray strobes
        repeat (4) @(posedge clk);

        for (int r = 0; r < NUM_ROWS; r++) begin
            fill_row_data(row_mode[r], row_seq[r]);
            exp_cnt = row_seq[r] - row_gram[r] + 1;
            for (int g = 0; g < exp_cnt; g++) begin
                exp_hash[g] = model_hash(g, row_gram[r]);
            end
            load_and_start(row_seq[r], row_gram[r]);
            // done marks the end of the job
            while (jobs_done < r + 1) begin
                @(posedge clk);
            end
            // quiet gap, a late strobe or second done trips the monitor
            repeat (3) @(posedge clk);
        end

        $display("test passed");
        $finish;
    end

endmodule

//--- sources.f
accel_cfg_pkg.sv
accel_types_pkg.sv
exec_if.sv
agu_next.sv
exe_ctrl.sv
src_buffer.sv
ngram_hasher.sv
dst_writer.sv
ngram_accel_top.sv
tb_ngram_accel.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_ngram_accel -o sim_ngram

# a failing run still leaves its log behind for the search below
./obj_dir/sim_ngram 2>&1 | tee sim.log

if grep -q "test passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
